/* project.f */
+incdir+hw
hw/rv_pkg.sv
hw/alu.sv
hw/reg_file.sv
hw/instr_decode.sv
hw/execute_stage.sv
hw/rv_exec_core.sv
sim/tb_rv_exec_core.sv

/* Makefile */
VERILATOR ?= verilator
TOP       := tb_rv_exec_core
FILELIST  := project.f
VFLAGS    := --binary --timing --top-module $(TOP)
BUILD_DIR := obj_dir
SIM_BIN   := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(wildcard hw/*.sv hw/*.svh sim/*.sv)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -q "Test completed successfully" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* sim/tb_rv_exec_core.sv */
module tb_rv_exec_core;
  import rv_pkg::*;

  localparam int         RETIRE_TIMEOUT = 10;
  localparam logic [6:0] OPC_LUI        = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC      = 7'b0010111;
  localparam logic [6:0] OPC_JAL        = 7'b1101111;
  localparam logic [6:0] OPC_JALR       = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH     = 7'b1100011;
  localparam logic [6:0] OPC_LOAD       = 7'b0000011;
  localparam logic [6:0] OPC_STORE      = 7'b0100011;
  localparam logic [6:0] OPC_IMM        = 7'b0010011;
  localparam logic [6:0] OPC_REG        = 7'b0110011;
  localparam logic [6:0] F7_ALT         = 7'b0100000;

  logic        clk;
  logic        rst;
  logic        issue_valid;
  issue_t      issue;
  logic        retire_valid;
  retire_t     retire;

  logic [31:0] rng = 32'hf70c;
  logic [31:0] cur_pc;
  logic [31:0] regs_model [32];
  logic [31:0] pc_q [$];
  int          cyc_q [$];
  int          cycle_count = 0;
  int          error_count = 0;
  int          check_count = 0;
  int          test_count = 0;

  rv_exec_core rv_exec_core_inst (
    .clk         (clk),
    .rst         (rst),
    .issue_valid (issue_valid),
    .issue       (issue),
    .retire_valid(retire_valid),
    .retire      (retire)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) cycle_count <= cycle_count + 1;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OPC_REG};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    check_count++;
    if (got !== exp) begin
      $display("ERROR %s: got %h, expected %h", name, got, exp);
      error_count++;
    end
  endtask

  // called on a falling edge, returns on the next one.
  task automatic issue_instr(input logic [31:0] instr);
    issue_valid = 1'b1;
    issue = {cur_pc, instr};
    pc_q.push_back(cur_pc);
    cyc_q.push_back(cycle_count); // edge that opens the strobe cycle.
    cur_pc = cur_pc + 32'd4;
    @(negedge clk);
    issue_valid = 1'b0;
  endtask

  task automatic expect_retire(input logic exp_write, input logic [4:0] exp_rd,
                               input logic [31:0] exp_value, input logic exp_taken,
                               input logic [31:0] exp_next, input logic exp_illegal);
    int          waited;
    int          issue_cyc;
    logic [31:0] exp_pc;
    waited = 0;
    while (!retire_valid && waited < RETIRE_TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (!retire_valid) begin
      $display("no retire record arrived within %0d cycles", RETIRE_TIMEOUT);
      error_count++;
      if (pc_q.size() > 0) begin
        exp_pc = pc_q.pop_front();
        issue_cyc = cyc_q.pop_front();
      end
    end else if (pc_q.size() == 0) begin
      $display("retire record arrived with no instruction outstanding");
      error_count++;
      @(negedge clk);
    end else begin
      exp_pc = pc_q.pop_front();
      issue_cyc = cyc_q.pop_front();
      check_value("retire.pc", retire.pc, exp_pc);
      check_value("retire.rd_write", 32'(retire.rd_write), 32'(exp_write));
      if (exp_write) begin
        check_value("retire.rd", 32'(retire.rd), 32'(exp_rd));
        check_value("retire.rd_value", retire.rd_value, exp_value);
        regs_model[exp_rd] = exp_value;
      end
      check_value("retire.branch_taken", 32'(retire.branch_taken), 32'(exp_taken));
      check_value("retire.next_pc", retire.next_pc, exp_next);
      check_value("retire.illegal", 32'(retire.illegal), 32'(exp_illegal));
      check_value("retire latency", 32'(cycle_count - issue_cyc), 32'd2);
      @(negedge clk);
    end
  endtask

  task automatic run_one(input logic [31:0] instr, input logic exp_write,
                         input logic [31:0] exp_value, input logic exp_taken,
                         input logic [31:0] exp_next, input logic exp_illegal);
    issue_instr(instr);
    expect_retire(exp_write, instr[11:7], exp_value, exp_taken, exp_next, exp_illegal);
  endtask

  task automatic run_write(input logic [31:0] instr, input logic [31:0] value);
    run_one(instr, instr[11:7] != 5'd0, value, 1'b0, cur_pc + 32'd4, 1'b0);
  endtask

  task automatic run_illegal(input logic [31:0] instr);
    run_one(instr, 1'b0, 32'd0, 1'b0, cur_pc + 32'd4, 1'b1);
  endtask

  // lui then addi, upper part rounded for the sign of the low 12 bits.
  task automatic load_reg(input logic [4:0] rd, input logic [31:0] value);
    logic [19:0] upper;
    upper = value[31:12] + {19'd0, value[11]};
    run_write({upper, rd, OPC_LUI}, {upper, 12'd0});
    run_write(enc_i(value[11:0], rd, 3'b000, rd, OPC_IMM), value);
  endtask

  task automatic report_test(input string name, input int errs_before);
    test_count++;
    if (error_count == errs_before) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, error_count - errs_before);
    end
  endtask

  task automatic test_arith();
    logic [31:0] a;
    logic [31:0] b;
    logic [4:0]  sh;
    logic [11:0] imm;
    int          errs;
    errs = error_count;
    for (int p = 0; p < 2; p++) begin
      rng = xorshift32(rng);
      a = rng;
      rng = xorshift32(rng);
      b = rng;
      sh = b[4:0];
      imm = a[23:12];
      load_reg(5'd1, a);
      load_reg(5'd2, b);
      run_write(enc_i(imm, 5'd1, 3'b000, 5'd3, OPC_IMM), a + {{20{imm[11]}}, imm});
      run_write(enc_r(7'd0, 5'd2, 5'd1, 3'b000, 5'd5), a + b);
      run_write(enc_r(F7_ALT, 5'd2, 5'd1, 3'b000, 5'd6), a - b);
      run_write(enc_r(7'd0, 5'd2, 5'd1, 3'b001, 5'd7), a << sh);
      run_write(enc_r(7'd0, 5'd2, 5'd1, 3'b010, 5'd8), {31'd0, $signed(a) < $signed(b)});
      run_write(enc_r(7'd0, 5'd2, 5'd1, 3'b011, 5'd9), {31'd0, a < b});
      run_write(enc_r(7'd0, 5'd2, 5'd1, 3'b100, 5'd10), a ^ b);
      run_write(enc_r(7'd0, 5'd2, 5'd1, 3'b101, 5'd11), a >> sh);
      run_write(enc_r(F7_ALT, 5'd2, 5'd1, 3'b101, 5'd12), 32'($signed(a) >>> sh));
      run_write(enc_r(7'd0, 5'd2, 5'd1, 3'b110, 5'd13), a | b);
      run_write(enc_r(7'd0, 5'd2, 5'd1, 3'b111, 5'd14), a & b);
    end
    report_test("arith", errs);
  endtask

  task automatic test_shift_imm();
    logic [31:0] a;
    logic [31:0] keep;
    logic [4:0]  sh;
    int          errs;
    errs = error_count;
    rng = xorshift32(rng);
    a = rng | 32'h8000_0000; // sign bit set for srai.
    rng = xorshift32(rng);
    keep = rng;
    sh = rng[8:4];
    load_reg(5'd1, a);
    load_reg(5'd16, keep);
    run_write(enc_i({7'd0, sh}, 5'd1, 3'b001, 5'd3, OPC_IMM), a << sh);
    run_write(enc_i({7'd0, sh}, 5'd1, 3'b101, 5'd4, OPC_IMM), a >> sh);
    run_write(enc_i({F7_ALT, sh}, 5'd1, 3'b101, 5'd15, OPC_IMM), 32'($signed(a) >>> sh));
    run_illegal(enc_i({F7_ALT, sh}, 5'd1, 3'b001, 5'd16, OPC_IMM));
    run_write(enc_i(12'd0, 5'd16, 3'b000, 5'd17, OPC_IMM), keep);
    report_test("shift_imm", errs);
  endtask

  task automatic test_branches();
    logic [4:0]  src1 [3];
    logic [4:0]  src2 [3];
    logic [2:0]  f3s [6];
    logic [31:0] ra;
    logic [31:0] rb;
    logic [12:0] off;
    logic        taken;
    int          errs;
    errs = error_count;
    src1 = '{5'd21, 5'd20, 5'd21};
    src2 = '{5'd22, 5'd21, 5'd20};
    f3s = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
    rng = xorshift32(rng);
    load_reg(5'd20, rng | 32'h8000_0000);
    rng = xorshift32(rng);
    load_reg(5'd21, rng & 32'h7fff_ffff);
    load_reg(5'd22, rng & 32'h7fff_ffff);
    for (int p = 0; p < 3; p++) begin
      for (int k = 0; k < 6; k++) begin
        ra = regs_model[src1[p]];
        rb = regs_model[src2[p]];
        off = k[0] ? 13'h1ff0 : 13'h0040;
        case (f3s[k])
          3'b000:  taken = (ra == rb);
          3'b001:  taken = (ra != rb);
          3'b100:  taken = ($signed(ra) < $signed(rb));
          3'b101:  taken = ($signed(ra) >= $signed(rb));
          3'b110:  taken = (ra < rb);
          default: taken = (ra >= rb);
        endcase
        run_one(enc_b(off, src2[p], src1[p], f3s[k]), 1'b0, 32'd0, taken,
                taken ? cur_pc + {{19{off[12]}}, off} : cur_pc + 32'd4, 1'b0);
      end
    end
    report_test("branches", errs);
  endtask

  task automatic test_upper_jumps();
    logic [31:0] base;
    logic [31:0] sum;
    logic [20:0] joff;
    logic [11:0] imm;
    int          errs;
    errs = error_count;
    rng = xorshift32(rng);
    run_write({rng[31:12], 5'd23, OPC_LUI}, {rng[31:12], 12'd0});
    rng = xorshift32(rng);
    run_write({rng[31:12], 5'd24, OPC_AUIPC}, cur_pc + {rng[31:12], 12'd0});
    rng = xorshift32(rng);
    joff = {rng[20:1], 1'b0};
    run_one(enc_j(joff, 5'd25), 1'b1, cur_pc + 32'd4, 1'b0,
            cur_pc + {{11{joff[20]}}, joff}, 1'b0);
    joff = 21'h1ffff8; // backwards by 8.
    run_one(enc_j(joff, 5'd0), 1'b0, 32'd0, 1'b0, cur_pc - 32'd8, 1'b0);
    rng = xorshift32(rng);
    base = rng;
    load_reg(5'd21, base);
    rng = xorshift32(rng);
    imm = {rng[11:1], ~base[0]}; // odd sum so bit 0 must be dropped.
    sum = base + {{20{imm[11]}}, imm};
    run_one(enc_i(imm, 5'd21, 3'b000, 5'd26, OPC_JALR), 1'b1, cur_pc + 32'd4, 1'b0,
            {sum[31:1], 1'b0}, 1'b0);
    report_test("upper_jumps", errs);
  endtask

  task automatic test_unsupported();
    int errs;
    errs = error_count;
    run_illegal(enc_i(12'h000, 5'd0, 3'b000, 5'd27, 7'b1111111));
    run_illegal(enc_i(12'h123, 5'd3, 3'b000, 5'd27, 7'b0000000));
    run_illegal(enc_i(12'h010, 5'd21, 3'b010, 5'd27, OPC_LOAD));
    run_illegal(enc_s(12'h020, 5'd22, 5'd21, 3'b010));
    run_illegal(enc_i(12'h0ff, 5'd0, 3'b000, 5'd27, 7'b0001111));
    run_illegal(enc_i(12'h000, 5'd0, 3'b000, 5'd27, 7'b1110011));
    run_illegal(enc_b(13'h0008, 5'd22, 5'd21, 3'b010));
    run_illegal(enc_b(13'h0008, 5'd22, 5'd21, 3'b011));
    run_write(enc_i(12'd0, 5'd27, 3'b000, 5'd28, OPC_IMM), regs_model[27]);
    run_write(enc_i(12'h155, 5'd21, 3'b000, 5'd0, OPC_IMM), 32'd0);
    run_write({20'habcde, 5'd0, OPC_LUI}, 32'd0);
    run_write(enc_r(7'd0, 5'd0, 5'd0, 3'b000, 5'd29), 32'd0);
    run_write(enc_i(12'd0, 5'd0, 3'b110, 5'd30, OPC_IMM), 32'd0);
    report_test("unsupported", errs);
  endtask

  task automatic test_back_to_back();
    logic [31:0] instrs [5];
    logic [31:0] vals [5];
    logic [31:0] pcs [5];
    logic [11:0] imm;
    int          errs;
    errs = error_count;
    rng = xorshift32(rng);
    imm = rng[11:0];
    vals[0] = {{20{imm[11]}}, imm};
    vals[1] = vals[0] + vals[0];
    vals[2] = vals[1] - vals[0];
    vals[3] = vals[2] ^ vals[1];
    vals[4] = vals[3] << 3;
    instrs[0] = enc_i(imm, 5'd0, 3'b000, 5'd5, OPC_IMM);
    instrs[1] = enc_r(7'd0, 5'd5, 5'd5, 3'b000, 5'd6);
    instrs[2] = enc_r(F7_ALT, 5'd5, 5'd6, 3'b000, 5'd7);
    instrs[3] = enc_r(7'd0, 5'd6, 5'd7, 3'b100, 5'd8);
    instrs[4] = enc_i(12'd3, 5'd8, 3'b001, 5'd9, OPC_IMM);
    for (int k = 0; k < 5; k++) begin
      pcs[k] = cur_pc + 32'(4 * k);
    end
    fork
      begin
        for (int k = 0; k < 5; k++) begin
          issue_instr(instrs[k]);
        end
      end
      begin
        for (int k = 0; k < 5; k++) begin
          expect_retire(1'b1, instrs[k][11:7], vals[k], 1'b0, pcs[k] + 32'd4, 1'b0);
        end
      end
    join
    report_test("back_to_back", errs);
  endtask

  initial begin
    rst = 1'b1;
    issue_valid = 1'b0;
    issue = '0;
    cur_pc = 32'h0000_1000;
    for (int k = 0; k < 32; k++) begin
      regs_model[k] = 32'd0;
    end
    repeat (16) @(negedge clk);
    rst = 1'b0;
    test_arith();
    test_shift_imm();
    test_branches();
    test_upper_jumps();
    test_unsupported();
    test_back_to_back();
    $display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
    if (error_count == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* hw/rv_exec_core.sv */
`include "rv_core_cfg.svh"

module rv_exec_core (
  input  logic            clk,
  input  logic            rst,
  input  logic            issue_valid,
  input  rv_pkg::issue_t  issue,
  output logic            retire_valid,
  output rv_pkg::retire_t retire
);
  import rv_pkg::*;

  logic                   dec_valid;
  decoded_t               dec;
  logic [`REG_ADDR_W-1:0] raddr1;
  logic [`REG_ADDR_W-1:0] raddr2;
  logic [`XLEN-1:0]       rdata1;
  logic [`XLEN-1:0]       rdata2;
  logic                   we;
  logic [`REG_ADDR_W-1:0] waddr;
  logic [`XLEN-1:0]       wdata;

  instr_decode instr_decode_inst (
    .clk        (clk),
    .rst        (rst),
    .issue_valid(issue_valid),
    .issue      (issue),
    .dec_valid  (dec_valid),
    .dec        (dec)
  );

  execute_stage execute_stage_inst (
    .clk         (clk),
    .rst         (rst),
    .dec_valid   (dec_valid),
    .dec         (dec),
    .raddr1      (raddr1),
    .raddr2      (raddr2),
    .rdata1      (rdata1),
    .rdata2      (rdata2),
    .we          (we),
    .waddr       (waddr),
    .wdata       (wdata),
    .retire_valid(retire_valid),
    .retire      (retire)
  );

  reg_file reg_file_inst (
    .clk   (clk),
    .rst   (rst),
    .raddr1(raddr1),
    .raddr2(raddr2),
    .rdata1(rdata1),
    .rdata2(rdata2),
    .we    (we),
    .waddr (waddr),
    .wdata (wdata)
  );

endmodule

/* hw/execute_stage.sv */
`include "rv_core_cfg.svh"

module execute_stage (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   dec_valid,
  input  rv_pkg::decoded_t       dec,
  output logic [`REG_ADDR_W-1:0] raddr1,
  output logic [`REG_ADDR_W-1:0] raddr2,
  input  logic [`XLEN-1:0]       rdata1,
  input  logic [`XLEN-1:0]       rdata2,
  output logic                   we,
  output logic [`REG_ADDR_W-1:0] waddr,
  output logic [`XLEN-1:0]       wdata,
  output logic                   retire_valid,
  output rv_pkg::retire_t        retire
);
  import rv_pkg::*;

  logic [`XLEN-1:0] op_b;
  logic [`XLEN-1:0] alu_y;
  logic [`XLEN-1:0] pc_plus4;
  logic [`XLEN-1:0] pc_plus_imm;
  logic [`XLEN-1:0] rd_value;
  logic [`XLEN-1:0] next_pc;
  logic             is_branch;
  logic             is_eq_branch;
  logic             cond;
  logic             branch_taken;
  logic             writes_rd;
  logic             rd_write;
  retire_t          retire_next;

  assign raddr1 = dec.rs1;
  assign raddr2 = dec.rs2;
  assign op_b   = dec.uses_imm ? dec.imm : rdata2;

  alu alu_inst (
    .op(dec.alu_op),
    .a (rdata1),
    .b (op_b),
    .y (alu_y)
  );

  assign pc_plus4    = dec.pc + `XLEN'(4);
  assign pc_plus_imm = dec.pc + dec.imm;

  // beq and bne compare through a subtract.
  assign is_branch    = (dec.fmt == FMT_B) && !dec.illegal;
  assign is_eq_branch = (dec.alu_op == ALU_SUB);
  assign cond         = is_eq_branch ? (alu_y == '0) : alu_y[0];
  assign branch_taken = is_branch && (cond ^ dec.branch_invert);

  always_comb begin
    if (dec.is_lui) begin
      rd_value = dec.imm;
    end else if (dec.is_auipc) begin
      rd_value = pc_plus_imm;
    end else if (dec.fmt == FMT_J) begin
      rd_value = pc_plus4; // link address.
    end else begin
      rd_value = alu_y;
    end
  end

  always_comb begin
    if ((dec.fmt == FMT_J) && dec.is_jalr) begin
      next_pc = {alu_y[`XLEN-1:1], 1'b0};
    end else if ((dec.fmt == FMT_J) || branch_taken) begin
      next_pc = pc_plus_imm;
    end else begin
      next_pc = pc_plus4;
    end
  end

  assign writes_rd = (dec.fmt == FMT_R) || (dec.fmt == FMT_I) ||
                     (dec.fmt == FMT_U) || (dec.fmt == FMT_J);
  assign rd_write  = dec_valid && !dec.illegal && writes_rd && (dec.rd != '0);

  // write lands on the same edge as the retire record.
  assign we    = rd_write;
  assign waddr = dec.rd;
  assign wdata = rd_value;

  always_comb begin
    retire_next.pc           = dec.pc;
    retire_next.rd           = dec.rd;
    retire_next.rd_value     = rd_value;
    retire_next.rd_write     = rd_write;
    retire_next.branch_taken = branch_taken;
    retire_next.next_pc      = next_pc;
    retire_next.illegal      = dec.illegal;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      retire_valid <= 1'b0;
    end else begin
      retire_valid <= dec_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (dec_valid) begin
      retire <= retire_next;
    end
  end

endmodule

/* hw/instr_decode.sv */
`include "rv_core_cfg.svh"

module instr_decode (
  input  logic             clk,
  input  logic             rst,
  input  logic             issue_valid,
  input  rv_pkg::issue_t   issue,
  output logic             dec_valid,
  output rv_pkg::decoded_t dec
);
  import rv_pkg::*;

  instr_word_u      iw;
  logic [31:0]      raw;
  opcode_t          opcode;
  logic [2:0]       funct3;
  logic [6:0]       funct7;
  logic             f7_zero;
  logic             f7_alt;
  instr_format_t    fmt;
  logic             is_jalr;
  logic             is_lui;
  logic             is_auipc;
  alu_op_t          r_op;
  alu_op_t          i_op;
  alu_op_t          b_op;
  alu_op_t          alu_op;
  logic [`XLEN-1:0] imm;
  logic             illegal;
  decoded_t         dec_next;

  assign iw      = issue.instr;
  assign raw     = issue.instr;
  assign opcode  = opcode_t'(iw.r.opcode);
  assign funct3  = raw[`FUNCT3_HI:`FUNCT3_LO];
  assign funct7  = raw[`FUNCT7_HI:`FUNCT7_LO];
  assign f7_zero = (funct7 == 7'b0000000);
  assign f7_alt  = (funct7 == 7'b0100000);

  always_comb begin
    case (opcode)
      OP_REG:    fmt = FMT_R;
      OP_IMM:    fmt = FMT_I;
      OP_LOAD:   fmt = FMT_L;
      OP_STORE:  fmt = FMT_S;
      OP_BRANCH: fmt = FMT_B;
      OP_LUI,
      OP_AUIPC:  fmt = FMT_U;
      OP_JAL,
      OP_JALR:   fmt = FMT_J; // jalr told apart by is_jalr.
      default:   fmt = FMT_BAD;
    endcase
  end

  assign is_jalr  = (opcode == OP_JALR);
  assign is_lui   = (opcode == OP_LUI);
  assign is_auipc = (opcode == OP_AUIPC);

  always_comb begin
    case (funct3)
      3'b000:  r_op = f7_alt ? ALU_SUB : (f7_zero ? ALU_ADD : ALU_INVALID);
      3'b001:  r_op = f7_zero ? ALU_SLL : ALU_INVALID;
      3'b010:  r_op = f7_zero ? ALU_SLT : ALU_INVALID;
      3'b011:  r_op = f7_zero ? ALU_SLTU : ALU_INVALID;
      3'b100:  r_op = f7_zero ? ALU_XOR : ALU_INVALID;
      3'b101:  r_op = f7_alt ? ALU_SRA : (f7_zero ? ALU_SRL : ALU_INVALID);
      3'b110:  r_op = f7_zero ? ALU_OR : ALU_INVALID;
      default: r_op = f7_zero ? ALU_AND : ALU_INVALID;
    endcase
  end

  // only the shifts look at the upper immediate bits.
  always_comb begin
    case (funct3)
      3'b000:  i_op = ALU_ADD;
      3'b001:  i_op = f7_zero ? ALU_SLL : ALU_INVALID;
      3'b010:  i_op = ALU_SLT;
      3'b011:  i_op = ALU_SLTU;
      3'b100:  i_op = ALU_XOR;
      3'b101:  i_op = f7_alt ? ALU_SRA : (f7_zero ? ALU_SRL : ALU_INVALID);
      3'b110:  i_op = ALU_OR;
      default: i_op = ALU_AND;
    endcase
  end

  always_comb begin
    case (funct3)
      3'b000, 3'b001: b_op = ALU_SUB;
      3'b100, 3'b101: b_op = ALU_SLT;
      3'b110, 3'b111: b_op = ALU_SLTU;
      default:        b_op = ALU_INVALID; // 010 and 011 are undefined.
    endcase
  end

  always_comb begin
    case (fmt)
      FMT_R:   alu_op = r_op;
      FMT_I:   alu_op = i_op;
      FMT_B:   alu_op = b_op;
      default: alu_op = ALU_ADD; // jalr target add.
    endcase
  end

  always_comb begin
    case (fmt)
      FMT_S:   imm = {{(`XLEN-12){iw.s.imm_11_5[6]}}, iw.s.imm_11_5, iw.s.imm_4_0};
      FMT_B:   imm = {{(`XLEN-13){iw.b.imm_12}}, iw.b.imm_12, iw.b.imm_11,
                      iw.b.imm_10_5, iw.b.imm_4_1, 1'b0};
      FMT_U:   imm = `XLEN'({iw.u.imm_31_12, 12'b0});
      FMT_J:   imm = is_jalr ? {{(`XLEN-12){iw.i.imm_11_0[11]}}, iw.i.imm_11_0}
                             : {{(`XLEN-21){iw.j.imm_20}}, iw.j.imm_20, iw.j.imm_19_12,
                                iw.j.imm_11, iw.j.imm_10_1, 1'b0};
      default: imm = {{(`XLEN-12){iw.i.imm_11_0[11]}}, iw.i.imm_11_0};
    endcase
  end

  assign illegal = (fmt == FMT_L) || (fmt == FMT_S) || (fmt == FMT_BAD) ||
                   (alu_op == ALU_INVALID);

  always_comb begin
    dec_next.pc            = issue.pc;
    dec_next.fmt           = fmt;
    dec_next.alu_op        = alu_op;
    dec_next.imm           = imm;
    dec_next.rs1           = iw.r.rs1;
    dec_next.rs2           = iw.r.rs2;
    dec_next.rd            = iw.r.rd;
    dec_next.uses_imm      = (fmt != FMT_R) && (fmt != FMT_B);
    dec_next.is_jalr       = is_jalr;
    dec_next.is_lui        = is_lui;
    dec_next.is_auipc      = is_auipc;
    dec_next.branch_invert = (fmt == FMT_B) && funct3[0];
    dec_next.illegal       = illegal;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      dec_valid <= 1'b0;
    end else begin
      dec_valid <= issue_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (issue_valid) begin
      dec <= dec_next;
    end
  end

endmodule

/* hw/reg_file.sv */
`include "rv_core_cfg.svh"

module reg_file (
  input  logic                   clk,
  input  logic                   rst,
  input  logic [`REG_ADDR_W-1:0] raddr1,
  input  logic [`REG_ADDR_W-1:0] raddr2,
  output logic [`XLEN-1:0]       rdata1,
  output logic [`XLEN-1:0]       rdata2,
  input  logic                   we,
  input  logic [`REG_ADDR_W-1:0] waddr,
  input  logic [`XLEN-1:0]       wdata
);

  logic [`XLEN-1:0] regs [`REG_COUNT];

  // x0 is cleared by reset and never written.
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int k = 0; k < `REG_COUNT; k++) begin
        regs[k] <= '0;
      end
    end else if (we && (waddr != '0)) begin
      regs[waddr] <= wdata;
    end
  end

  assign rdata1 = regs[raddr1];
  assign rdata2 = regs[raddr2];

endmodule

/* hw/alu.sv */
`include "rv_core_cfg.svh"

module alu (
  input  rv_pkg::alu_op_t  op,
  input  logic [`XLEN-1:0] a,
  input  logic [`XLEN-1:0] b,
  output logic [`XLEN-1:0] y
);
  import rv_pkg::*;

  logic [$clog2(`XLEN)-1:0] shamt;
  logic                     lt_signed;
  logic                     lt_unsigned;

  assign shamt       = b[$clog2(`XLEN)-1:0]; // low bits only.
  assign lt_signed   = $signed(a) < $signed(b);
  assign lt_unsigned = a < b;

  always_comb begin
    case (op)
      ALU_ADD:  y = a + b;
      ALU_SUB:  y = a - b;
      ALU_SLL:  y = a << shamt;
      ALU_SLT:  y = {{(`XLEN-1){1'b0}}, lt_signed};
      ALU_SLTU: y = {{(`XLEN-1){1'b0}}, lt_unsigned};
      ALU_XOR:  y = a ^ b;
      ALU_SRL:  y = a >> shamt;
      ALU_SRA:  y = $signed(a) >>> shamt;
      ALU_OR:   y = a | b;
      ALU_AND:  y = a & b;
      default:  y = '0;
    endcase
  end

endmodule

/* hw/rv_pkg.sv */
`include "rv_core_cfg.svh"

package rv_pkg;

  typedef enum logic [6:0] {
    OP_LUI    = 7'b0110111,
    OP_AUIPC  = 7'b0010111,
    OP_JAL    = 7'b1101111,
    OP_JALR   = 7'b1100111,
    OP_BRANCH = 7'b1100011,
    OP_LOAD   = 7'b0000011,
    OP_STORE  = 7'b0100011,
    OP_IMM    = 7'b0010011,
    OP_REG    = 7'b0110011
  } opcode_t;

  typedef enum logic [2:0] {
    FMT_R   = 3'd0,
    FMT_I   = 3'd1,
    FMT_L   = 3'd2,
    FMT_S   = 3'd3,
    FMT_B   = 3'd4,
    FMT_U   = 3'd5,
    FMT_J   = 3'd6,
    FMT_BAD = 3'd7
  } instr_format_t;

  typedef enum logic [3:0] {
    ALU_ADD     = 4'd0,
    ALU_SUB     = 4'd1,
    ALU_SLL     = 4'd2,
    ALU_SLT     = 4'd3,
    ALU_SLTU    = 4'd4,
    ALU_XOR     = 4'd5,
    ALU_SRL     = 4'd6,
    ALU_SRA     = 4'd7,
    ALU_OR      = 4'd8,
    ALU_AND     = 4'd9,
    ALU_INVALID = 4'd15
  } alu_op_t;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_view_t;

  typedef struct packed {
    logic [11:0] imm_11_0;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_view_t;

  typedef struct packed {
    logic [6:0] imm_11_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_4_0;
    logic [6:0] opcode;
  } s_view_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } b_view_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_view_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_view_t;

  typedef union packed {
    r_view_t r;
    i_view_t i;
    s_view_t s;
    b_view_t b;
    u_view_t u;
    j_view_t j;
  } instr_word_u;

  typedef struct packed {
    logic [`XLEN-1:0] pc;
    instr_word_u      instr;
  } issue_t;

  typedef struct packed {
    logic [`XLEN-1:0]       pc;
    instr_format_t          fmt;
    alu_op_t                alu_op;
    logic [`XLEN-1:0]       imm;
    logic [`REG_ADDR_W-1:0] rs1;
    logic [`REG_ADDR_W-1:0] rs2;
    logic [`REG_ADDR_W-1:0] rd;
    logic                   uses_imm;
    logic                   is_jalr;
    logic                   is_lui;
    logic                   is_auipc;
    logic                   branch_invert; // bne, bge, bgeu.
    logic                   illegal;
  } decoded_t;

  typedef struct packed {
    logic [`XLEN-1:0]       pc;
    logic [`REG_ADDR_W-1:0] rd;
    logic [`XLEN-1:0]       rd_value;
    logic                   rd_write;
    logic                   branch_taken;
    logic [`XLEN-1:0]       next_pc;
    logic                   illegal;
  } retire_t;

endpackage

/* hw/rv_core_cfg.svh */
`ifndef RV_CORE_CFG_SVH
`define RV_CORE_CFG_SVH

// datapath and register file sizes.
`define XLEN       32
`define REG_COUNT  32
`define REG_ADDR_W 5

// function fields of the instruction word.
`define FUNCT3_HI  14
`define FUNCT3_LO  12
`define FUNCT7_HI  31
`define FUNCT7_LO  25

`endif
